/* hw/lsu_agu_queue.sv */
module lsu_agu_queue import lsu_pkg::*; #(
	parameter int lq_depth = 2,
	parameter int sq_depth = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  ls_kind_t kind,
	input  logic [((lq_depth > sq_depth) ? $clog2(lq_depth) : $clog2(sq_depth))-1:0] slot,
	input  logic     base_valid,
	input  tag_t     base_tag,
	input  addr_t    base_data,
	input  offset_t  offset,
	input  logic     gpr_cdb_valid,
	input  tag_t     gpr_cdb_tag,
	input  word_t    gpr_cdb_data,
	input  logic     lq_pop,
	input  logic     sq_pop,
	output logic     full,
	output logic     agu_fire,
	output ls_kind_t agu_kind,
	output logic [((lq_depth > sq_depth) ? $clog2(lq_depth) : $clog2(sq_depth))-1:0] agu_slot,
	output addr_t    agu_addr
);
	localparam int slot_w = (lq_depth > sq_depth) ? $clog2(lq_depth) : $clog2(sq_depth);

	logic              e_valid [2];
	ls_kind_t          e_kind [2];
	logic [slot_w-1:0] e_slot [2];
	logic              e_ok [2];
	tag_t              e_tag [2];
	addr_t             e_base [2];
	offset_t           e_off [2];

	logic              sel;
	logic              fire_0, fire_1;

	assign fire_0 = e_valid[0] && e_ok[0];
	assign fire_1 = e_valid[1] && e_ok[1];
	assign agu_fire = fire_0 || fire_1;
	assign sel = fire_0 ? 1'b0 : 1'b1; // oldest ready entry
	assign agu_kind = e_kind[sel];
	assign agu_slot = e_slot[sel];
	assign agu_addr = e_base[sel] + addr_t'(e_off[sel]);
	assign full = e_valid[1];

	always_ff @(posedge clk) begin
		int k;
		k = 0;
		if (reset) begin
			e_valid[0] <= 1'b0;
			e_valid[1] <= 1'b0;
		end else begin
			e_valid[0] <= 1'b0;
			e_valid[1] <= 1'b0;
			for (int i = 0; i < 2; i++) begin
				if (e_valid[i] && !(agu_fire && sel == 1'(i))) begin
					e_valid[k] <= 1'b1;
					e_kind[k]  <= e_kind[i];
					// follow the target entry as its queue shifts
					if (e_kind[i] == LOAD)
						e_slot[k] <= e_slot[i] - slot_w'(lq_pop);
					else
						e_slot[k] <= e_slot[i] - slot_w'(sq_pop);
					e_ok[k]  <= e_ok[i] || (gpr_cdb_valid && gpr_cdb_tag == e_tag[i]);
					e_base[k] <= e_ok[i] ? e_base[i] : gpr_cdb_data[9:0];
					e_tag[k] <= e_tag[i];
					e_off[k] <= e_off[i];
					k++;
				end
			end
			if (push) begin
				e_valid[k] <= 1'b1;
				e_kind[k]  <= kind;
				e_slot[k]  <= slot; // already adjusted for this cycle's pop
				e_ok[k]    <= base_valid || (gpr_cdb_valid && gpr_cdb_tag == base_tag);
				e_base[k]  <= base_valid ? base_data : gpr_cdb_data[9:0];
				e_tag[k]   <= base_tag;
				e_off[k]   <= offset;
			end
		end
	end
endmodule

/* hw/lsu_data_mem.sv */
module lsu_data_mem import lsu_pkg::*; (
	input  logic  clk,
	input  logic  we,
	input  addr_t waddr,
	input  word_t wdata,
	input  addr_t raddr,
	output word_t rdata
);
	word_t mem [1024];

	initial begin
		for (int i = 0; i < 1024; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // old word on a same-cycle write
	end
endmodule

/* hw/lsu_load_queue.sv */
module lsu_load_queue import lsu_pkg::*; #(
	parameter int lq_depth = 2,
	parameter int sq_depth = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      push,
	input  reg_file_t reg_file,
	input  tag_t      dest_tag,
	input  logic      addr_known,
	input  addr_t     imm_addr,
	input  logic      agu_fire,
	input  ls_kind_t  agu_kind,
	input  logic [$clog2(lq_depth)-1:0] agu_slot,
	input  addr_t     agu_addr,
	input  logic      sq_pop,
	input  logic [$clog2(sq_depth+1)-1:0] sq_count,
	input  logic [$clog2(sq_depth+1)-1:0] sq_resolved,
	input  logic      fwd_hit,
	input  word_t     fwd_data,
	input  word_t     mem_rdata,
	input  logic      gpr_req_ready,
	input  logic      fpr_req_ready,
	output logic      gpr_req_valid,
	output logic      fpr_req_valid,
	output tag_t      result_tag,
	output word_t     result_data,
	output logic      lq_pop,
	output addr_t     head_addr,
	output logic [$clog2(sq_depth+1)-1:0] head_older,
	output addr_t     next_head_addr,
	output logic [$clog2(lq_depth+1)-1:0] count,
	output logic [$clog2(lq_depth)-1:0] slot
);
	localparam int lq_cw = $clog2(lq_depth + 1);
	localparam int sq_cw = $clog2(sq_depth + 1);

	tag_t             e_tag [lq_depth];
	reg_file_t        e_rf [lq_depth];
	addr_t            e_addr [lq_depth];
	logic             e_known [lq_depth];
	logic [sq_cw-1:0] e_older [lq_depth];

	tag_t             n_tag [lq_depth];
	reg_file_t        n_rf [lq_depth];
	addr_t            n_addr [lq_depth];
	logic             n_known [lq_depth];
	logic [sq_cw-1:0] n_older [lq_depth];

	logic             head_ready;

	// head may go once every older store is resolved
	assign head_ready = count != '0 && e_known[0] && sq_resolved >= e_older[0];
	assign gpr_req_valid = head_ready && e_rf[0] == GPR;
	assign fpr_req_valid = head_ready && e_rf[0] == FPR;
	assign lq_pop = (gpr_req_valid && gpr_req_ready) || (fpr_req_valid && fpr_req_ready);
	assign result_tag = e_tag[0];
	assign result_data = fwd_hit ? fwd_data : mem_rdata;
	assign head_addr = e_addr[0];
	assign head_older = e_older[0];
	assign slot = $clog2(lq_depth)'(count - lq_cw'(lq_pop));
	assign next_head_addr = n_addr[0]; // memory word lines up with next head

	always_comb begin
		int src;
		for (int i = 0; i < lq_depth; i++) begin
			src = lq_pop ? i + 1 : i;
			if (src < lq_depth) begin
				n_tag[i]   = e_tag[src];
				n_rf[i]    = e_rf[src];
				n_older[i] = (e_older[src] != '0 && sq_pop) ? e_older[src] - 1'b1 : e_older[src];
				if (agu_fire && agu_kind == LOAD && agu_slot == src) begin
					n_addr[i]  = agu_addr;
					n_known[i] = 1'b1;
				end else begin
					n_addr[i]  = e_addr[src];
					n_known[i] = e_known[src];
				end
			end else begin
				n_tag[i]   = e_tag[i];
				n_rf[i]    = e_rf[i];
				n_older[i] = e_older[i];
				n_addr[i]  = e_addr[i];
				n_known[i] = e_known[i];
			end
			if (push && slot == i) begin
				n_tag[i]   = dest_tag;
				n_rf[i]    = reg_file;
				n_addr[i]  = imm_addr;
				n_known[i] = addr_known;
				n_older[i] = sq_count - sq_cw'(sq_pop);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < lq_depth; i++) begin
			e_tag[i]   <= n_tag[i];
			e_rf[i]    <= n_rf[i];
			e_addr[i]  <= n_addr[i];
			e_known[i] <= n_known[i];
			e_older[i] <= n_older[i];
		end
		if (reset)
			count <= '0;
		else
			count <= count + lq_cw'(push) - lq_cw'(lq_pop);
	end
endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

	// data memory word address
	typedef logic [9:0] addr_t;

	typedef logic [31:0] word_t;

	// rob tag of a pending result
	typedef logic [3:0] tag_t;

	typedef logic signed [9:0] offset_t;

	// bit 0 immediate address, bit 1 fp register, bit 2 store
	typedef logic [2:0] mem_op_t;

	typedef enum logic {
		LOAD  = 1'b0,
		STORE = 1'b1
	} ls_kind_t;

	typedef enum logic {
		GPR = 1'b0,
		FPR = 1'b1
	} reg_file_t;

endpackage

/* hw/lsu_store_queue.sv */
module lsu_store_queue import lsu_pkg::*; #(
	parameter int sq_depth = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      push,
	input  reg_file_t reg_file,
	input  logic      addr_known,
	input  addr_t     imm_addr,
	input  logic      st_valid,
	input  tag_t      st_tag,
	input  word_t     st_data,
	input  logic      gpr_cdb_valid,
	input  tag_t      gpr_cdb_tag,
	input  word_t     gpr_cdb_data,
	input  logic      fpr_cdb_valid,
	input  tag_t      fpr_cdb_tag,
	input  word_t     fpr_cdb_data,
	input  logic      agu_fire,
	input  ls_kind_t  agu_kind,
	input  logic [$clog2(sq_depth)-1:0] agu_slot,
	input  addr_t     agu_addr,
	input  logic      commit_valid,
	input  addr_t     head_addr,
	input  logic [$clog2(sq_depth+1)-1:0] head_older,
	output logic      commit_ready,
	output logic      sq_pop,
	output logic [$clog2(sq_depth+1)-1:0] count,
	output logic [$clog2(sq_depth)-1:0] slot,
	output logic [$clog2(sq_depth+1)-1:0] sq_resolved,
	output logic      fwd_hit,
	output word_t     fwd_data,
	output logic      mem_we,
	output addr_t     mem_waddr,
	output word_t     mem_wdata
);
	localparam int sq_cw = $clog2(sq_depth + 1);

	addr_t     e_addr [sq_depth];
	logic      e_known [sq_depth];
	reg_file_t e_rf [sq_depth];
	logic      e_ok [sq_depth];
	tag_t      e_tag [sq_depth];
	word_t     e_data [sq_depth];

	// store that committed last cycle
	logic      last_valid;
	addr_t     last_addr;
	word_t     last_data;

	assign commit_ready = count != '0 && e_known[0] && e_ok[0];
	assign sq_pop = commit_valid && commit_ready;
	assign mem_we = sq_pop;
	assign mem_waddr = e_addr[0];
	assign mem_wdata = e_data[0];
	assign slot = $clog2(sq_depth)'(count - sq_cw'(sq_pop));

	always_comb begin
		logic run;
		run = 1'b1;
		sq_resolved = '0;
		for (int i = 0; i < sq_depth; i++) begin
			if (run && i < count && e_known[i] && e_ok[i])
				sq_resolved = sq_resolved + 1'b1;
			else
				run = 1'b0;
		end
	end

	// youngest older match wins, committed record is the fallback
	always_comb begin
		fwd_hit = last_valid && last_addr == head_addr;
		fwd_data = last_data;
		for (int i = 0; i < sq_depth; i++) begin
			if (i < head_older && e_addr[i] == head_addr) begin
				fwd_hit = 1'b1;
				fwd_data = e_data[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		int src;
		logic hit;
		for (int i = 0; i < sq_depth; i++) begin
			src = sq_pop ? i + 1 : i;
			if (src < sq_depth) begin
				e_rf[i]  <= e_rf[src];
				e_tag[i] <= e_tag[src];
				if (agu_fire && agu_kind == STORE && agu_slot == src) begin
					e_addr[i]  <= agu_addr;
					e_known[i] <= 1'b1;
				end else begin
					e_addr[i]  <= e_addr[src];
					e_known[i] <= e_known[src];
				end
				hit = e_rf[src] == GPR ? gpr_cdb_valid && gpr_cdb_tag == e_tag[src]
				                       : fpr_cdb_valid && fpr_cdb_tag == e_tag[src];
				e_ok[i] <= e_ok[src] || hit;
				if (!e_ok[src])
					e_data[i] <= e_rf[src] == GPR ? gpr_cdb_data : fpr_cdb_data;
				else
					e_data[i] <= e_data[src];
			end
			if (push && slot == i) begin
				e_rf[i]    <= reg_file;
				e_tag[i]   <= st_tag;
				e_addr[i]  <= imm_addr;
				e_known[i] <= addr_known;
				hit = reg_file == GPR ? gpr_cdb_valid && gpr_cdb_tag == st_tag
				                      : fpr_cdb_valid && fpr_cdb_tag == st_tag;
				e_ok[i] <= st_valid || hit;
				if (st_valid)
					e_data[i] <= st_data;
				else
					e_data[i] <= reg_file == GPR ? gpr_cdb_data : fpr_cdb_data;
			end
		end
		last_addr <= e_addr[0];
		last_data <= e_data[0];
		if (reset) begin
			count <= '0;
			last_valid <= 1'b0;
		end else begin
			count <= count + sq_cw'(push) - sq_cw'(sq_pop);
			last_valid <= sq_pop;
		end
	end
endmodule

/* hw/lsu_top.sv */
module lsu_top import lsu_pkg::*; #(
	parameter int lq_depth = 2,
	parameter int sq_depth = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    issue_valid,
	output logic    issue_ready,
	input  mem_op_t op,
	input  addr_t   imm_addr,
	input  offset_t offset,
	input  logic    base_valid,
	input  tag_t    base_tag,
	input  addr_t   base_data,
	input  logic    st_valid,
	input  tag_t    st_tag,
	input  word_t   st_data,
	input  tag_t    dest_tag,
	input  logic    gpr_cdb_valid,
	input  tag_t    gpr_cdb_tag,
	input  word_t   gpr_cdb_data,
	input  logic    fpr_cdb_valid,
	input  tag_t    fpr_cdb_tag,
	input  word_t   fpr_cdb_data,
	output logic    gpr_req_valid,
	input  logic    gpr_req_ready,
	output logic    fpr_req_valid,
	input  logic    fpr_req_ready,
	output tag_t    result_tag,
	output word_t   result_data,
	input  logic    commit_valid,
	output logic    commit_ready
);
	localparam int lq_pw = $clog2(lq_depth);
	localparam int sq_pw = $clog2(sq_depth);
	localparam int sq_cw = $clog2(sq_depth + 1);
	localparam int slot_w = (lq_depth > sq_depth) ? lq_pw : sq_pw;

	ls_kind_t          kind;
	reg_file_t         reg_file;
	logic              imm, accept;
	logic              agu_full, agu_fire;
	ls_kind_t          agu_kind;
	logic [slot_w-1:0] agu_slot, new_slot;
	addr_t             agu_addr;
	logic              lq_pop, sq_pop;
	logic [$clog2(lq_depth+1)-1:0] lq_count;
	logic [lq_pw-1:0]  lq_slot;
	logic [sq_cw-1:0]  sq_count, sq_resolved, head_older;
	logic [sq_pw-1:0]  sq_slot;
	addr_t             head_addr, next_head_addr;
	logic              fwd_hit;
	word_t             fwd_data, mem_rdata;
	logic              mem_we;
	addr_t             mem_waddr;
	word_t             mem_wdata;

	assign kind = op[2] ? STORE : LOAD;
	assign reg_file = op[1] ? FPR : GPR;
	assign imm = op[0];

	// a leaving entry frees its place this cycle
	assign issue_ready = (imm || !agu_full || agu_fire) &&
	                     (kind == STORE || lq_count < lq_depth || lq_pop) &&
	                     (kind == LOAD || sq_count < sq_depth || sq_pop);
	assign accept = issue_valid && issue_ready;
	assign new_slot = kind == LOAD ? slot_w'(lq_slot) : slot_w'(sq_slot);

	lsu_agu_queue #(.lq_depth(lq_depth), .sq_depth(sq_depth)) i_agu (
		.clk, .reset, .push(accept && !imm), .kind, .slot(new_slot),
		.base_valid, .base_tag, .base_data, .offset,
		.gpr_cdb_valid, .gpr_cdb_tag, .gpr_cdb_data, .lq_pop, .sq_pop,
		.full(agu_full), .agu_fire, .agu_kind, .agu_slot, .agu_addr
	);

	lsu_load_queue #(.lq_depth(lq_depth), .sq_depth(sq_depth)) i_lq (
		.clk, .reset, .push(accept && kind == LOAD), .reg_file, .dest_tag,
		.addr_known(imm), .imm_addr, .agu_fire, .agu_kind,
		.agu_slot(agu_slot[lq_pw-1:0]), .agu_addr, .sq_pop, .sq_count, .sq_resolved,
		.fwd_hit, .fwd_data, .mem_rdata, .gpr_req_ready, .fpr_req_ready,
		.gpr_req_valid, .fpr_req_valid, .result_tag, .result_data, .lq_pop,
		.head_addr, .head_older, .next_head_addr, .count(lq_count), .slot(lq_slot)
	);

	lsu_store_queue #(.sq_depth(sq_depth)) i_sq (
		.clk, .reset, .push(accept && kind == STORE), .reg_file, .addr_known(imm),
		.imm_addr, .st_valid, .st_tag, .st_data,
		.gpr_cdb_valid, .gpr_cdb_tag, .gpr_cdb_data,
		.fpr_cdb_valid, .fpr_cdb_tag, .fpr_cdb_data,
		.agu_fire, .agu_kind, .agu_slot(agu_slot[sq_pw-1:0]), .agu_addr,
		.commit_valid, .head_addr, .head_older, .commit_ready, .sq_pop,
		.count(sq_count), .slot(sq_slot), .sq_resolved, .fwd_hit, .fwd_data,
		.mem_we, .mem_waddr, .mem_wdata
	);

	lsu_data_mem i_mem (
		.clk, .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
		.raddr(next_head_addr), .rdata(mem_rdata)
	);
endmodule

/* project.f */
hw/lsu_pkg.sv
hw/lsu_agu_queue.sv
hw/lsu_load_queue.sv
hw/lsu_store_queue.sv
hw/lsu_data_mem.sv
hw/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal --top-module lsu_tb \
	-f project.f -o lsu_sim > build.log 2>&1 &&
	./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q '^TEST PASS$' sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

/* test/lsu_assert.sv */
module lsu_assert import lsu_pkg::*; #(
	parameter int lq_depth = 2,
	parameter int sq_depth = 4
) (
	input logic  clk,
	input logic  reset,
	input logic  issue_ready,
	input logic  gpr_req_valid,
	input logic  gpr_req_ready,
	input logic  fpr_req_valid,
	input logic  fpr_req_ready,
	input logic  commit_ready,
	input tag_t  result_tag,
	input word_t result_data,
	input logic [$clog2(lq_depth+1)-1:0] lq_count,
	input logic [$clog2(sq_depth+1)-1:0] sq_count
);
	timeunit 1ns;
	timeprecision 100ps;

	logic seen_edge = 1'b0; // queue counts settle at the first reset edge
	int failures = 0;

	always @(posedge clk)
		seen_edge <= 1'b1;

	quiet_in_reset: assert property (@(posedge clk)
		reset && seen_edge |-> !gpr_req_valid && !fpr_req_valid && !commit_ready)
		else begin
			failures++;
			$error("request or commit_ready high during reset");
		end

	one_bus: assert property (@(posedge clk) disable iff (reset)
		!(gpr_req_valid && fpr_req_valid))
		else begin
			failures++;
			$error("both result requests high");
		end

	gpr_hold: assert property (@(posedge clk) disable iff (reset)
		gpr_req_valid && !gpr_req_ready |=>
		gpr_req_valid && $stable(result_tag) && $stable(result_data))
		else begin
			failures++;
			$error("gpr result changed while stalled");
		end

	fpr_hold: assert property (@(posedge clk) disable iff (reset)
		fpr_req_valid && !fpr_req_ready |=>
		fpr_req_valid && $stable(result_tag) && $stable(result_data))
		else begin
			failures++;
			$error("fpr result changed while stalled");
		end

	idle_ready: assert property (@(posedge clk) disable iff (reset)
		lq_count == '0 && sq_count == '0 |-> issue_ready)
		else begin
			failures++;
			$error("issue_ready low with empty queues");
		end
endmodule

bind lsu_top lsu_assert #(.lq_depth(lq_depth), .sq_depth(sq_depth)) i_lsu_assert (
	.clk, .reset, .issue_ready, .gpr_req_valid, .gpr_req_ready,
	.fpr_req_valid, .fpr_req_ready, .commit_ready, .result_tag, .result_data,
	.lq_count, .sq_count
);

/* test/lsu_tb.sv */
module lsu_tb import lsu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_instr = 300;
	localparam int max_cycles = 4000;

	logic clk = 1'b0;
	logic reset, issue_valid, issue_ready, base_valid, st_valid;
	mem_op_t op;
	addr_t imm_addr, base_data;
	offset_t offset;
	tag_t base_tag, st_tag, dest_tag, gpr_cdb_tag, fpr_cdb_tag, result_tag;
	word_t st_data, gpr_cdb_data, fpr_cdb_data, result_data;
	logic gpr_cdb_valid, fpr_cdb_valid, gpr_req_valid, gpr_req_ready;
	logic fpr_req_valid, fpr_req_ready, commit_valid, commit_ready;

	word_t model [1024]; // program order memory

	// operand tags still owed on a CDB
	logic p_busy [16];
	logic p_active [16];
	int p_wait [16];
	reg_file_t p_rf [16];
	word_t p_data [16];

	tag_t exp_tag [$];
	word_t exp_data [$];
	reg_file_t exp_rf [$];

	int errors = 0;
	int proto_errors = 0;
	int cycles = 0;
	int issued = 0;
	int loads_issued = 0;
	int loads_done = 0;
	int st_loads [$]; // loads ahead of each uncommitted store
	int stall = 0;
	int cur_t0, cur_t1;
	addr_t cur_addr;
	word_t cur_data;
	logic taken;

	lsu_top i_lsu_top (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, %0d loads and %0d stores still outstanding",
				cycles, exp_tag.size(), st_loads.size());
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic int free_tag();
		for (int i = 0; i < 16; i++)
			if (!p_busy[i])
				return i;
		return 0;
	endfunction

	function automatic int take_tag(reg_file_t rf, word_t data);
		int t;
		t = free_tag();
		p_busy[t] = 1'b1;
		p_active[t] = 1'b0; // starts counting once accepted
		p_rf[t] = rf;
		p_data[t] = data;
		return t;
	endfunction

	task automatic make_instr();
		logic is_store, is_imm, is_fp;
		addr_t target;
		int o;
		is_store = $urandom % 5 < 2;
		is_imm = $urandom % 2;
		is_fp = $urandom % 3 == 0;
		target = addr_t'(16 + $urandom % 6); // few addresses, many overlaps
		o = int'($urandom % 128) - 64;
		op = {is_store, is_fp, is_imm};
		imm_addr = is_imm ? target : addr_t'($urandom);
		offset = offset_t'(o);
		base_data = target - addr_t'(o);
		base_valid = $urandom % 2;
		base_tag = tag_t'($urandom);
		cur_t0 = -1;
		cur_t1 = -1;
		if (!is_imm && !base_valid) begin
			cur_t0 = take_tag(GPR, {22'($urandom), base_data});
			base_tag = tag_t'(cur_t0);
		end
		cur_data = $urandom;
		st_valid = $urandom % 2;
		st_tag = tag_t'($urandom);
		st_data = st_valid ? cur_data : $urandom;
		if (is_store && !st_valid) begin
			cur_t1 = take_tag(is_fp ? FPR : GPR, cur_data);
			st_tag = tag_t'(cur_t1);
		end
		dest_tag = tag_t'(issued);
		cur_addr = target;
		issue_valid = 1'b1;
	endtask

	task automatic accept_instr();
		if (cur_t0 >= 0) begin
			p_active[cur_t0] = 1'b1;
			p_wait[cur_t0] = $urandom % 7;
		end
		if (cur_t1 >= 0) begin
			p_active[cur_t1] = 1'b1;
			p_wait[cur_t1] = $urandom % 7;
		end
		if (op[2]) begin
			model[cur_addr] = cur_data;
			st_loads.push_back(loads_issued);
		end else begin
			exp_tag.push_back(dest_tag);
			exp_data.push_back(model[cur_addr]);
			exp_rf.push_back(op[1] ? FPR : GPR);
			loads_issued++;
		end
		issued++;
		taken = 1'b1;
	endtask

	task automatic check_result(input reg_file_t bus);
		tag_t t;
		word_t d;
		reg_file_t rf;
		if (exp_tag.size() == 0) begin
			proto_errors++;
			$display("%0t: result on the %s bus while no load is outstanding", $time, bus.name());
		end else begin
			t = exp_tag.pop_front();
			d = exp_data.pop_front();
			rf = exp_rf.pop_front();
			loads_done++;
			if (rf != bus) begin
				errors++;
				$display("CHECK FAILED %0t req_valid bus: expected %s actual %s",
					$time, rf.name(), bus.name());
			end
			if (result_tag !== t) begin
				errors++;
				$display("CHECK FAILED %0t result_tag: expected %h actual %h", $time, t, result_tag);
			end
			if (result_data !== d) begin
				errors++;
				$display("CHECK FAILED %0t result_data: expected %h actual %h", $time, d, result_data);
			end
		end
	endtask

	task automatic step();
		int g, f;
		if (taken) begin
			issue_valid = 1'b0;
			taken = 1'b0;
		end
		g = -1;
		f = -1;
		for (int i = 0; i < 16; i++) begin
			if (p_busy[i] && p_active[i] && p_wait[i] == 0) begin
				if (p_rf[i] == GPR && g < 0)
					g = i;
				else if (p_rf[i] == FPR && f < 0)
					f = i;
			end
		end
		gpr_cdb_valid = g >= 0;
		gpr_cdb_tag = tag_t'(g);
		gpr_cdb_data = g >= 0 ? p_data[g] : '0;
		fpr_cdb_valid = f >= 0;
		fpr_cdb_tag = tag_t'(f);
		fpr_cdb_data = f >= 0 ? p_data[f] : '0;
		for (int i = 0; i < 16; i++)
			if (p_busy[i] && p_active[i] && p_wait[i] > 0)
				p_wait[i]--;
		if (!issue_valid && issued < n_instr && $urandom % 5 != 0)
			make_instr();
		// freed only now so a new operand never sees its tag on the bus
		if (g >= 0)
			p_busy[g] = 1'b0;
		if (f >= 0)
			p_busy[f] = 1'b0;
		if (stall > 0)
			stall--;
		else if ($urandom % 40 == 0)
			stall = 8 + $urandom % 16;
		gpr_req_ready = stall == 0 && $urandom % 4 != 0;
		fpr_req_ready = stall == 0 && $urandom % 4 != 0;
		// rob retires a store only behind every older load
		commit_valid = st_loads.size() != 0 && loads_done >= st_loads[0] && $urandom % 2 == 1;
		#1;
		if (issue_valid && issue_ready)
			accept_instr();
		if (gpr_req_valid && gpr_req_ready)
			check_result(GPR);
		if (fpr_req_valid && fpr_req_ready)
			check_result(FPR);
		if (commit_valid && commit_ready)
			void'(st_loads.pop_front());
	endtask

	initial begin
		void'($urandom(49));
		reset = 1'b1;
		issue_valid = 1'b0;
		op = '0;
		imm_addr = '0;
		offset = '0;
		base_valid = 1'b0;
		base_tag = '0;
		base_data = '0;
		st_valid = 1'b0;
		st_tag = '0;
		st_data = '0;
		dest_tag = '0;
		gpr_cdb_valid = 1'b0;
		gpr_cdb_tag = '0;
		gpr_cdb_data = '0;
		fpr_cdb_valid = 1'b0;
		fpr_cdb_tag = '0;
		fpr_cdb_data = '0;
		gpr_req_ready = 1'b0;
		fpr_req_ready = 1'b0;
		commit_valid = 1'b0;
		taken = 1'b0;
		for (int i = 0; i < 1024; i++)
			model[i] = '0;
		for (int i = 0; i < 16; i++) begin
			p_busy[i] = 1'b0;
			p_active[i] = 1'b0;
			p_wait[i] = 0;
		end
		repeat (16) @(negedge clk);
		reset = 1'b0;
		while (issued < n_instr || exp_tag.size() != 0 || st_loads.size() != 0) begin
			@(negedge clk);
			step();
		end
		$display("errors: %0d value mismatches, %0d protocol errors, %0d assertion failures",
			errors, proto_errors, i_lsu_top.i_lsu_assert.failures);
		if (errors + proto_errors + i_lsu_top.i_lsu_assert.failures == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule
